// File: hdl/mmc_defs.svh
/*
 * Encodings, field widths and buffer depths for the maintenance controller.
 * Only RV64 base encodings for FENCE.I and SFENCE.VMA are matched.
 * Credit counts must equal the buffer depths they guard.
 */
`ifndef MMC_DEFS_SVH
`define MMC_DEFS_SVH

// Instruction and address field widths
`define MMC_ILEN            32
`define MMC_VPN_LEN         27
`define MMC_ASID_LEN        16
`define MMC_OPCODE_LEN      7
`define MMC_FUNCT3_LEN      3
`define MMC_FUNCT7_LEN      7
`define MMC_REG_LEN         5

// Major opcodes
`define MMC_OPCODE_MISC_MEM 7'b0001111
`define MMC_OPCODE_SYSTEM   7'b1110011

// Minor encodings
`define MMC_FUNCT3_FENCE_I  3'b001
`define MMC_FUNCT3_PRIV     3'b000
`define MMC_FUNCT7_SFENCE_VMA 7'b0001001

// Event buffer depth, also the core credits after reset
`define MMC_EV_DEPTH        4
// Action buffer depth, also the decoder credits
`define MMC_ACT_DEPTH       2
// Commands the memory side can absorb
`define MMC_CMD_CREDITS     2

`endif

// File: hdl/mmc_pkg.sv
/*
 * Types shared by the maintenance controller stages.
 * Exception causes follow the RISC-V privileged spec, 4-bit subset only.
 * Events with causes outside the enum are legal and decode to no action.
 */
`include "mmc_defs.svh"

package mmc_pkg;

	// RISC-V synchronous exception causes
	typedef enum logic [3:0] {
		exc_instr_misaligned = 4'd0,
		exc_instr_access     = 4'd1,
		exc_illegal_instr    = 4'd2,
		exc_load_misaligned  = 4'd4,
		exc_load_access      = 4'd5,
		exc_store_misaligned = 4'd6,
		exc_store_access     = 4'd7,
		exc_ecall_smode      = 4'd9,
		exc_ecall_mmode      = 4'd11,
		exc_instr_page_fault = 4'd12,
		exc_load_page_fault  = 4'd13,
		exc_store_page_fault = 4'd15
	} exc_code_e;

	// TLB flush scope
	typedef enum logic [1:0] {
		flush_none = 2'd0,
		flush_all  = 2'd1,
		flush_asid = 2'd2,
		flush_page = 2'd3
	} tlb_flush_e;

	// One retired event from the core
	typedef struct packed {
		// Set for exceptions, clear for retired instructions
		logic                       exc;
		exc_code_e                  code;
		logic [`MMC_ILEN-1:0]       instr;
		// Faulting page, or page operand of SFENCE.VMA
		logic [`MMC_VPN_LEN-1:0]    vpn;
		// ASID active when the event retired
		logic [`MMC_ASID_LEN-1:0]   asid;
	} mmc_event_t;

	// Decoded maintenance work for one event
	typedef struct packed {
		logic                       abort;
		logic                       clr_tlb_mshr;
		logic                       clr_dmshr;
		logic                       sync_l1d;
		tlb_flush_e                 flush_type;
		logic [`MMC_ASID_LEN-1:0]   asid;
		logic [`MMC_VPN_LEN-1:0]    vpn;
		// Came from an exception, drives the pipeline flush
		logic                       exc;
	} mmc_action_t;

	// Command toward TLBs, caches and L2 arbiter
	typedef struct packed {
		logic                       abort;
		logic                       clr_tlb_mshr;
		logic                       clr_dmshr;
		logic                       sync_l1d;
		tlb_flush_e                 flush_type;
		logic [`MMC_ASID_LEN-1:0]   asid;
		logic [`MMC_VPN_LEN-1:0]    vpn;
	} mmc_cmd_t;

endpackage

// File: hdl/mmc_credit_fifo.sv
/*
 * Circular buffer whose pops return one credit pulse a cycle later.
 * Producer must hold a credit per push; a push while full is dropped.
 * Data out is the head entry, valid only while valid_o is high.
 */
module mmc_credit_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 2
) (
	input  logic     clk_i,
	input  logic     rst_n_i,
	input  logic     push_i,
	input  payload_t data_i,
	output logic     valid_o,
	output payload_t data_o,
	input  logic     pop_i,
	output logic     credit_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t           mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               full;
	logic               do_push;
	logic               do_pop;

	assign full    = (count == CNT_W'(DEPTH));
	assign valid_o = (count != '0);
	assign data_o  = mem[rd_ptr];

	// Handshakes that actually move an entry
	assign do_push = push_i && !full;
	assign do_pop  = pop_i && valid_o;

	// Storage, no reset
	always_ff @(posedge clk_i) begin
		if (do_push) begin
			mem[wr_ptr] <= data_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			// Explicit wrap so any depth works
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count    <= count + CNT_W'(do_push) - CNT_W'(do_pop);
			// Freed slot goes back to the producer
			credit_o <= do_pop;
		end
	end

endmodule

// File: hdl/mmc_event_decode.sv
/*
 * Classifies retired events into maintenance actions.
 * An exception flag overrides the instruction word.
 * Events with no action keep their action credit and push nothing.
 */
`include "mmc_defs.svh"

module mmc_event_decode (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                ev_valid_i,
	input  mmc_pkg::mmc_event_t ev_i,
	output logic                ev_pop_o,
	input  logic                act_credit_i,
	output logic                act_push_o,
	output mmc_pkg::mmc_action_t act_o
);

	localparam int CRD_W = $clog2(`MMC_ACT_DEPTH + 1);

	logic [CRD_W-1:0]             act_credits;
	logic [`MMC_OPCODE_LEN-1:0]   opcode;
	logic [`MMC_FUNCT3_LEN-1:0]   funct3;
	logic [`MMC_FUNCT7_LEN-1:0]   funct7;
	logic [`MMC_REG_LEN-1:0]      rs1;
	logic [`MMC_REG_LEN-1:0]      rs2;
	logic                         is_fence_i;
	logic                         is_sfence;
	logic                         dec_hit;
	logic                         take;
	mmc_pkg::mmc_action_t         dec_act;

	// Standard R-type field positions
	assign opcode = ev_i.instr[`MMC_OPCODE_LEN-1:0];
	assign funct3 = ev_i.instr[14:12];
	assign rs1    = ev_i.instr[19:15];
	assign rs2    = ev_i.instr[24:20];
	assign funct7 = ev_i.instr[31:25];

	assign is_fence_i = (opcode == `MMC_OPCODE_MISC_MEM) && (funct3 == `MMC_FUNCT3_FENCE_I);
	assign is_sfence  = (opcode == `MMC_OPCODE_SYSTEM) && (funct3 == `MMC_FUNCT3_PRIV)
		&& (funct7 == `MMC_FUNCT7_SFENCE_VMA);

	always_comb begin
		dec_act            = '0;
		dec_act.flush_type = mmc_pkg::flush_none;
		dec_act.exc        = ev_i.exc;
		dec_hit            = 1'b1;
		if (ev_i.exc) begin
			case (ev_i.code)
				mmc_pkg::exc_instr_misaligned, mmc_pkg::exc_instr_access: begin
					dec_act.clr_tlb_mshr = 1'b1;
					dec_act.flush_type   = mmc_pkg::flush_all;
				end
				mmc_pkg::exc_instr_page_fault: begin
					dec_act.clr_tlb_mshr = 1'b1;
					dec_act.flush_type   = mmc_pkg::flush_page;
					dec_act.vpn          = ev_i.vpn;
				end
				mmc_pkg::exc_load_page_fault, mmc_pkg::exc_store_page_fault: begin
					dec_act.clr_dmshr  = 1'b1;
					dec_act.flush_type = mmc_pkg::flush_page;
					dec_act.vpn        = ev_i.vpn;
				end
				mmc_pkg::exc_load_misaligned, mmc_pkg::exc_load_access,
				mmc_pkg::exc_store_misaligned, mmc_pkg::exc_store_access: begin
					dec_act.clr_dmshr  = 1'b1;
					dec_act.flush_type = mmc_pkg::flush_all;
				end
				mmc_pkg::exc_illegal_instr: begin
					dec_act.abort      = 1'b1;
					dec_act.flush_type = mmc_pkg::flush_all;
				end
				mmc_pkg::exc_ecall_smode, mmc_pkg::exc_ecall_mmode: begin
					dec_act.sync_l1d   = 1'b1;
					dec_act.flush_type = mmc_pkg::flush_all;
				end
				// Breakpoint, U-mode ecall, reserved
				default: dec_hit = 1'b0;
			endcase
		end else if (is_sfence) begin
			dec_act.clr_tlb_mshr = 1'b1;
			dec_act.clr_dmshr    = 1'b1;
			dec_act.sync_l1d     = 1'b1;
			// rs1 names a page, rs2 names an address space
			if (rs1 != '0) begin
				dec_act.flush_type = mmc_pkg::flush_page;
				dec_act.vpn        = ev_i.vpn;
			end else if (rs2 != '0) begin
				dec_act.flush_type = mmc_pkg::flush_asid;
				dec_act.asid       = ev_i.asid;
			end else begin
				dec_act.flush_type = mmc_pkg::flush_all;
			end
		end else if (is_fence_i) begin
			dec_act.clr_tlb_mshr = 1'b1;
		end else begin
			dec_hit = 1'b0;
		end
	end

	// Pop only with a slot reserved downstream
	assign ev_pop_o = ev_valid_i && (act_credits != '0);
	assign take     = ev_pop_o && dec_hit;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			act_credits <= CRD_W'(`MMC_ACT_DEPTH);
			act_push_o  <= 1'b0;
		end else begin
			act_credits <= act_credits - CRD_W'(take) + CRD_W'(act_credit_i);
			act_push_o  <= take;
		end
	end

	// Action payload, no reset
	always_ff @(posedge clk_i) begin
		if (take) begin
			act_o <= dec_act;
		end
	end

endmodule

// File: hdl/mmc_sync_sequencer.sv
/*
 * Issues one command per action, in order, against memory-side credits.
 * Sync actions hold in a wait state until L2 reports done.
 * One action in flight at a time, so at most one command every two cycles.
 */
`include "mmc_defs.svh"

module mmc_sync_sequencer (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 act_valid_i,
	input  mmc_pkg::mmc_action_t act_i,
	output logic                 act_pop_o,
	output logic                 sync_req_o,
	input  logic                 sync_done_i,
	input  logic                 cmd_credit_i,
	output logic                 cmd_valid_o,
	output mmc_pkg::mmc_cmd_t    cmd_o,
	output logic                 flush_o
);

	localparam int CRD_W = $clog2(`MMC_CMD_CREDITS + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_sync_wait,
		st_issue
	} seq_state_e;

	seq_state_e            state_q;
	seq_state_e            state_d;
	logic [CRD_W-1:0]      cmd_credits;
	logic                  issue;
	mmc_pkg::mmc_action_t  act_q;

	// Take a new action only when nothing is pending
	assign act_pop_o = (state_q == st_idle) && act_valid_i;

	// Level request for the whole wait
	assign sync_req_o = (state_q == st_sync_wait);

	// Issue needs a free slot on the memory side
	assign issue       = (state_q == st_issue) && (cmd_credits != '0);
	assign cmd_valid_o = issue;
	assign flush_o     = issue && act_q.exc;

	// Command carries everything but the exception flag
	assign cmd_o.abort        = act_q.abort;
	assign cmd_o.clr_tlb_mshr = act_q.clr_tlb_mshr;
	assign cmd_o.clr_dmshr    = act_q.clr_dmshr;
	assign cmd_o.sync_l1d     = act_q.sync_l1d;
	assign cmd_o.flush_type   = act_q.flush_type;
	assign cmd_o.asid         = act_q.asid;
	assign cmd_o.vpn          = act_q.vpn;

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (act_pop_o) begin
					state_d = act_i.sync_l1d ? st_sync_wait : st_issue;
				end
			end
			st_sync_wait: begin
				// Done pulse arrives while the request is up
				if (sync_done_i) begin
					state_d = st_issue;
				end
			end
			st_issue: begin
				if (issue) begin
					state_d = st_idle;
				end
			end
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= st_idle;
			cmd_credits <= CRD_W'(`MMC_CMD_CREDITS);
		end else begin
			state_q     <= state_d;
			// Spend on issue, regain on each returned pulse
			cmd_credits <= cmd_credits - CRD_W'(issue) + CRD_W'(cmd_credit_i);
		end
	end

	// Pending action, held through sync and credit stalls
	always_ff @(posedge clk_i) begin
		if (act_pop_o) begin
			act_q <= act_i;
		end
	end

endmodule

// File: hdl/mmc_top.sv
/*
 * Event buffer, decoder, action buffer and sequencer in a chain.
 * Core starts with MMC_EV_DEPTH credits, one pulse on ev_credit_o per freed slot.
 * Memory side returns one cmd_credit_i pulse per consumed command.
 */
`include "mmc_defs.svh"

module mmc_top (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                ev_valid_i,
	input  mmc_pkg::mmc_event_t ev_i,
	output logic                ev_credit_o,
	output logic                cmd_valid_o,
	output mmc_pkg::mmc_cmd_t   cmd_o,
	input  logic                cmd_credit_i,
	output logic                sync_req_o,
	input  logic                sync_done_i,
	output logic                flush_o
);

	// Event buffer to decoder
	logic                  ev_buf_valid;
	mmc_pkg::mmc_event_t   ev_buf_data;
	logic                  ev_pop;

	// Decoder to action buffer
	logic                  act_push;
	mmc_pkg::mmc_action_t  act_data;
	logic                  act_credit;

	// Action buffer to sequencer
	logic                  act_buf_valid;
	mmc_pkg::mmc_action_t  act_buf_data;
	logic                  act_pop;

	mmc_credit_fifo #(
		.payload_t (mmc_pkg::mmc_event_t),
		.DEPTH     (`MMC_EV_DEPTH)
	) u_ev_fifo (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.push_i   (ev_valid_i),
		.data_i   (ev_i),
		.valid_o  (ev_buf_valid),
		.data_o   (ev_buf_data),
		.pop_i    (ev_pop),
		.credit_o (ev_credit_o)
	);

	mmc_event_decode u_decode (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.ev_valid_i   (ev_buf_valid),
		.ev_i         (ev_buf_data),
		.ev_pop_o     (ev_pop),
		.act_credit_i (act_credit),
		.act_push_o   (act_push),
		.act_o        (act_data)
	);

	mmc_credit_fifo #(
		.payload_t (mmc_pkg::mmc_action_t),
		.DEPTH     (`MMC_ACT_DEPTH)
	) u_act_fifo (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.push_i   (act_push),
		.data_i   (act_data),
		.valid_o  (act_buf_valid),
		.data_o   (act_buf_data),
		.pop_i    (act_pop),
		.credit_o (act_credit)
	);

	mmc_sync_sequencer u_seq (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.act_valid_i  (act_buf_valid),
		.act_i        (act_buf_data),
		.act_pop_o    (act_pop),
		.sync_req_o   (sync_req_o),
		.sync_done_i  (sync_done_i),
		.cmd_credit_i (cmd_credit_i),
		.cmd_valid_o  (cmd_valid_o),
		.cmd_o        (cmd_o),
		.flush_o      (flush_o)
	);

endmodule

// File: test/mmc_chk.sv
/*
 * Credit and handshake assertions, bound into every mmc_top.
 * Buffer occupancy is rebuilt here from the push and pop strobes.
 * assert_fails counts failed assertions for the testbench.
 */
`include "mmc_defs.svh"

module mmc_chk (
	input logic clk_i,
	input logic rst_n_i,
	input logic ev_push_i,
	input logic ev_pop_i,
	input logic act_push_i,
	input logic act_pop_i,
	input logic cmd_valid_i,
	input logic cmd_credit_i,
	input logic sync_req_i,
	input logic sync_done_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int ev_cnt;
	int act_cnt;
	// Commands issued and not yet credited back
	int out_cnt;
	int assert_fails = 0;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ev_cnt  <= 0;
			act_cnt <= 0;
			out_cnt <= 0;
		end else begin
			ev_cnt  <= ev_cnt + int'(ev_push_i) - int'(ev_pop_i);
			act_cnt <= act_cnt + int'(act_push_i) - int'(act_pop_i);
			out_cnt <= out_cnt + int'(cmd_valid_i) - int'(cmd_credit_i);
		end
	end

	ev_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		ev_push_i |-> (ev_cnt < `MMC_EV_DEPTH))
		else begin
			assert_fails++;
			$error("Event buffer pushed while full");
		end

	act_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		act_push_i |-> (act_cnt < `MMC_ACT_DEPTH))
		else begin
			assert_fails++;
			$error("Action buffer pushed while full");
		end

	cmd_in_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		out_cnt <= `MMC_CMD_CREDITS)
		else begin
			assert_fails++;
			$error("More commands outstanding than memory-side credits");
		end

	// Request is a level held until L2 answers
	sync_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(sync_req_i && !sync_done_i) |=> sync_req_i)
		else begin
			assert_fails++;
			$error("sync_req_o dropped before sync_done_i");
		end

endmodule

bind mmc_top mmc_chk u_chk (
	.clk_i        (clk_i),
	.rst_n_i      (rst_n_i),
	.ev_push_i    (ev_valid_i),
	.ev_pop_i     (ev_pop),
	.act_push_i   (act_push),
	.act_pop_i    (act_pop),
	.cmd_valid_i  (cmd_valid_o),
	.cmd_credit_i (cmd_credit_i),
	.sync_req_i   (sync_req_o),
	.sync_done_i  (sync_done_i)
);

// File: test/mmc_tb.sv
/*
 * Random retired-event stream against mmc_top, memory side modelled here.
 * Expected commands come from a decode model and are kept in event order.
 * Memory credits return after 0 to 5 cycles, sync done after 1 to 8 cycles.
 */
`include "mmc_defs.svh"

module mmc_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_EVENTS      = 400;
	localparam int WATCHDOG_CYCLES = NUM_EVENTS * 40;

	// Expected command plus the flush it should raise
	typedef struct packed {
		logic              exc;
		mmc_pkg::mmc_cmd_t cmd;
	} exp_cmd_t;

	logic                clk_i;
	logic                rst_n_i;
	logic                ev_valid_i;
	mmc_pkg::mmc_event_t ev_i;
	logic                ev_credit_o;
	logic                cmd_valid_o;
	mmc_pkg::mmc_cmd_t   cmd_o;
	logic                cmd_credit_i;
	logic                sync_req_o;
	logic                sync_done_i;
	logic                flush_o;

	exp_cmd_t exp_q[$];
	string    name_q[$];
	// Cycle numbers at which memory credits go back
	int       credit_due_q[$];
	int       core_credits   = `MMC_EV_DEPTH;
	int       cycle          = 0;
	int       last_due       = 0;
	logic     sync_seen      = 1'b0;
	logic     sync_done_seen = 1'b0;

	mmc_top UUT (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.ev_valid_i   (ev_valid_i),
		.ev_i         (ev_i),
		.ev_credit_o  (ev_credit_o),
		.cmd_valid_o  (cmd_valid_o),
		.cmd_o        (cmd_o),
		.cmd_credit_i (cmd_credit_i),
		.sync_req_o   (sync_req_o),
		.sync_done_i  (sync_done_i),
		.flush_o      (flush_o)
	);

	initial clk_i = 1'b0;
	always #10 clk_i = ~clk_i;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			abort_run("Value mismatch");
		end
	endtask

	task automatic check_idle_outputs(input string phase);
		check_value({phase, "_ev_credit"}, 64'd0, 64'(ev_credit_o));
		check_value({phase, "_cmd_valid"}, 64'd0, 64'(cmd_valid_o));
		check_value({phase, "_sync_req"}, 64'd0, 64'(sync_req_o));
		check_value({phase, "_flush"}, 64'd0, 64'(flush_o));
	endtask

	// Decode rules for one event, returns 1 when a command is due
	function automatic logic model_decode(input mmc_pkg::mmc_event_t ev,
		output exp_cmd_t exp, output string name);
		logic [6:0] opcode;
		logic [2:0] funct3;
		logic [6:0] funct7;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic       hit;
		opcode = ev.instr[6:0];
		funct3 = ev.instr[14:12];
		rs1    = ev.instr[19:15];
		rs2    = ev.instr[24:20];
		funct7 = ev.instr[31:25];
		exp    = '0;
		hit    = 1'b1;
		name   = "other";
		if (ev.exc) begin
			exp.exc = 1'b1;
			name    = $sformatf("exc%0d", ev.code);
			exp.cmd.flush_type = mmc_pkg::flush_all;
			case (ev.code)
				mmc_pkg::exc_instr_misaligned, mmc_pkg::exc_instr_access:
					exp.cmd.clr_tlb_mshr = 1'b1;
				mmc_pkg::exc_instr_page_fault: begin
					exp.cmd.clr_tlb_mshr = 1'b1;
					exp.cmd.flush_type   = mmc_pkg::flush_page;
					exp.cmd.vpn          = ev.vpn;
				end
				mmc_pkg::exc_load_page_fault, mmc_pkg::exc_store_page_fault: begin
					exp.cmd.clr_dmshr  = 1'b1;
					exp.cmd.flush_type = mmc_pkg::flush_page;
					exp.cmd.vpn        = ev.vpn;
				end
				mmc_pkg::exc_load_misaligned, mmc_pkg::exc_load_access,
				mmc_pkg::exc_store_misaligned, mmc_pkg::exc_store_access:
					exp.cmd.clr_dmshr = 1'b1;
				mmc_pkg::exc_illegal_instr:
					exp.cmd.abort = 1'b1;
				mmc_pkg::exc_ecall_smode, mmc_pkg::exc_ecall_mmode:
					exp.cmd.sync_l1d = 1'b1;
				default:
					hit = 1'b0;
			endcase
		end else if (opcode == `MMC_OPCODE_SYSTEM && funct3 == `MMC_FUNCT3_PRIV
			&& funct7 == `MMC_FUNCT7_SFENCE_VMA) begin
			name = "sfence_vma";
			exp.cmd.clr_tlb_mshr = 1'b1;
			exp.cmd.clr_dmshr    = 1'b1;
			exp.cmd.sync_l1d     = 1'b1;
			if (rs1 != 5'd0) begin
				exp.cmd.flush_type = mmc_pkg::flush_page;
				exp.cmd.vpn        = ev.vpn;
			end else if (rs2 != 5'd0) begin
				exp.cmd.flush_type = mmc_pkg::flush_asid;
				exp.cmd.asid       = ev.asid;
			end else begin
				exp.cmd.flush_type = mmc_pkg::flush_all;
			end
		end else if (opcode == `MMC_OPCODE_MISC_MEM && funct3 == `MMC_FUNCT3_FENCE_I) begin
			name = "fence_i";
			exp.cmd.clr_tlb_mshr = 1'b1;
		end else begin
			hit = 1'b0;
		end
		return hit;
	endfunction

	// Half exceptions, the rest FENCE.I, SFENCE.VMA or random words
	function automatic mmc_pkg::mmc_event_t random_event();
		mmc_pkg::mmc_event_t ev;
		int unsigned         kind;
		logic [4:0]          rs1;
		logic [4:0]          rs2;
		kind     = $urandom_range(0, 9);
		ev.exc   = (kind < 5);
		ev.code  = mmc_pkg::exc_code_e'(4'($urandom_range(0, 15)));
		ev.instr = $urandom();
		ev.vpn   = `MMC_VPN_LEN'($urandom());
		ev.asid  = `MMC_ASID_LEN'($urandom());
		rs1      = ($urandom_range(0, 2) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
		rs2      = ($urandom_range(0, 2) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
		if (kind == 5) begin
			ev.instr = {ev.instr[31:20], rs1, `MMC_FUNCT3_FENCE_I, ev.instr[11:7],
				`MMC_OPCODE_MISC_MEM};
		end else if (kind == 6 || kind == 7) begin
			ev.instr = {`MMC_FUNCT7_SFENCE_VMA, rs2, rs1, `MMC_FUNCT3_PRIV, 5'd0,
				`MMC_OPCODE_SYSTEM};
		end
		return ev;
	endfunction

	initial begin
		int                  sent;
		mmc_pkg::mmc_event_t ev;
		exp_cmd_t            exp;
		string               name;
		rst_n_i      = 1'b0;
		ev_valid_i   = 1'b0;
		ev_i         = '0;
		cmd_credit_i = 1'b0;
		sync_done_i  = 1'b0;
		void'($urandom(83));
		repeat (4) begin
			@(negedge clk_i);
			check_idle_outputs("during_reset");
		end
		@(posedge clk_i);
		#2 rst_n_i = 1'b1;
		@(negedge clk_i);
		check_idle_outputs("after_reset");

		// Core side, sends only while holding a credit
		sent = 0;
		while (sent < NUM_EVENTS) begin
			@(posedge clk_i);
			#2;
			if (core_credits > 0 && $urandom_range(0, 9) < 7) begin
				ev         = random_event();
				ev_valid_i = 1'b1;
				ev_i       = ev;
				core_credits--;
				sent++;
				if (model_decode(ev, exp, name)) begin
					exp_q.push_back(exp);
					name_q.push_back(name);
				end
			end else begin
				ev_valid_i = 1'b0;
			end
		end
		@(posedge clk_i);
		#2 ev_valid_i = 1'b0;

		// Drain, then give stray commands time to show up
		while (exp_q.size() != 0 || core_credits != `MMC_EV_DEPTH) begin
			@(negedge clk_i);
		end
		repeat (20) @(negedge clk_i);
		check_value("core_credits", 64'(`MMC_EV_DEPTH), 64'(core_credits));
		if (UUT.u_chk.assert_fails == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			abort_run("Errors were recorded during the run");
		end
	end

	// Output monitor, sampled mid-cycle
	always @(negedge clk_i) begin
		exp_cmd_t exp;
		string    name;
		int       due;
		if (rst_n_i) begin
			if (ev_credit_o) begin
				core_credits++;
			end
			if (sync_req_o) begin
				sync_seen = 1'b1;
			end
			if (sync_req_o && sync_done_i) begin
				sync_done_seen = 1'b1;
			end
			if (UUT.u_chk.assert_fails != 0) begin
				abort_run("A protocol assertion in the checker failed");
			end else if (cmd_valid_o && exp_q.size() == 0) begin
				abort_run("A command was issued that no event called for");
			end else if (cmd_valid_o) begin
				exp  = exp_q.pop_front();
				name = name_q.pop_front();
				check_value({name, "_cmd"}, 64'(exp.cmd), 64'(cmd_o));
				check_value({name, "_flush"}, 64'(exp.exc), 64'(flush_o));
				if (exp.cmd.sync_l1d) begin
					check_value({name, "_sync_done_first"}, 64'd1, 64'(sync_done_seen));
				end else begin
					check_value({name, "_no_sync_req"}, 64'd0, 64'(sync_seen));
				end
				sync_seen      = 1'b0;
				sync_done_seen = 1'b0;
				// One credit pulse per cycle at most
				due = cycle + 1 + $urandom_range(0, 5);
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				credit_due_q.push_back(due);
			end else begin
				check_value("flush_without_cmd", 64'd0, 64'(flush_o));
			end
		end
	end

	// Memory side credit return
	always @(posedge clk_i) begin
		cycle++;
		#2;
		if (credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
			cmd_credit_i = 1'b1;
			void'(credit_due_q.pop_front());
		end else begin
			cmd_credit_i = 1'b0;
		end
	end

	// L2 answers each sync request with a single done pulse
	initial begin
		int unsigned delay;
		forever begin
			@(negedge clk_i);
			if (sync_req_o) begin
				delay = $urandom_range(1, 8);
				repeat (delay) @(posedge clk_i);
				#2 sync_done_i = 1'b1;
				@(posedge clk_i);
				#2 sync_done_i = 1'b0;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		abort_run("Timeout: the run hung before all events were drained");
	end

endmodule

// File: mmc_top.f
+incdir+hdl
hdl/mmc_pkg.sv
hdl/mmc_credit_fifo.sv
hdl/mmc_event_decode.sv
hdl/mmc_sync_sequencer.sv
hdl/mmc_top.sv
test/mmc_chk.sv
test/mmc_tb.sv

// File: Bender.yml
package:
  name: mmc

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mmc_pkg.sv
      - hdl/mmc_credit_fifo.sv
      - hdl/mmc_event_decode.sv
      - hdl/mmc_sync_sequencer.sv
      - hdl/mmc_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/mmc_chk.sv
      - test/mmc_tb.sv
